// ==== rtl/sd_init_pkg.sv ====
// SD command layer package with bus constants, enums and reply helpers
`default_nettype none

package sd_init_pkg;

    localparam int SD_CLK_DIV    = 4;                       // i_clk cycles per card clock half period
    localparam int SD_CLK_CNT_W  = $clog2(SD_CLK_DIV);
    localparam int PRE_INIT_CLKS = 75;                      // At least 74 clocks before CMD0
    localparam int RESP_TIMEOUT  = 64;                      // Card clocks to wait for a start bit

    localparam logic [3:0]  CMD8_VHS     = 4'b0001;         // 2.7-3.6 V
    localparam logic [7:0]  CMD8_PATTERN = 8'h55;
    localparam logic [23:0] OCR_WINDOW   = 24'hFF8000;

    typedef enum logic [5:0] {
        CMD0   = 6'd0,
        CMD2   = 6'd2,
        CMD3   = 6'd3,
        CMD8   = 6'd8,
        CMD11  = 6'd11,
        ACMD41 = 6'd41,
        CMD55  = 6'd55
    } sd_cmd_e;

    typedef enum logic [2:0] {RESP_NONE, R1, R2, R3, R6, R7} sd_resp_e;

    typedef enum logic [1:0] {ERR_NONE, ERR_NO_RESPONSE, ERR_CRC, ERR_INDEX} sd_cmd_err_e;

    typedef enum logic [2:0] {
        ST_PRE_INIT, ST_IDLE, ST_READY, ST_IDENT, ST_STBY, ST_INA
    } sd_state_e;

    typedef enum logic [2:0] {
        TYPE_UNKNOWN, TYPE_V1X, TYPE_V2X_SC, TYPE_V2X_HC, TYPE_UNUSABLE
    } sd_type_e;

    // Reply length in bits, start and end bit included
    function automatic logic [7:0] resp_len(sd_resp_e kind);
        return (kind == R2) ? 8'd136 : 8'd48;
    endfunction

    // Reply kinds that echo the command index and carry a checked CRC7
    function automatic logic resp_echo(sd_resp_e kind);
        return (kind == R1) || (kind == R6) || (kind == R7);
    endfunction

endpackage

`default_nettype wire

// ==== rtl/sd_clk_gen.sv ====
// Card clock divider with one-cycle rise and fall strobes
`default_nettype none

module sd_clk_gen import sd_init_pkg::*; (
    input  wire  i_clk,
    input  wire  i_nrst,
    output logic o_sd_clk,
    output logic o_sclk_rise,                               // High in the cycle o_sd_clk goes high
    output logic o_sclk_fall                                // High in the cycle o_sd_clk goes low
);

    logic [SD_CLK_CNT_W-1:0] cnt;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt         <= '0;
            o_sd_clk    <= 1'b0;
            o_sclk_rise <= 1'b0;
            o_sclk_fall <= 1'b0;
        end else begin
            o_sclk_rise <= 1'b0;
            o_sclk_fall <= 1'b0;
            if (cnt == SD_CLK_CNT_W'(SD_CLK_DIV - 1)) begin
                cnt         <= '0;
                o_sd_clk    <= ~o_sd_clk;
                o_sclk_rise <= ~o_sd_clk;
                o_sclk_fall <= o_sd_clk;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Edges alternate, so a rise and a fall never share a cycle
    a_strobes_exclusive: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_sclk_rise && o_sclk_fall));

endmodule

`default_nettype wire

// ==== rtl/sd_crc7.sv ====
// Serial CRC7 over command and reply bits, polynomial x^7 + x^3 + 1
`default_nettype none

module sd_crc7 (
    input  wire        i_clk,
    input  wire        i_nrst,
    input  wire        i_clear,                             // Wins over i_next
    input  wire        i_next,
    input  wire        i_dat,
    output logic [6:0] o_crc7
);

    logic fb;

    assign fb = i_dat ^ o_crc7[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_crc7 <= '0;
        end else if (i_clear) begin
            o_crc7 <= '0;
        end else if (i_next) begin
            // Feedback enters at bit 0 and at the x^3 tap
            o_crc7 <= {o_crc7[5:3], o_crc7[2] ^ fb, o_crc7[1:0], fb};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sd_cmd_trx.sv ====
// Command engine that sends one 48-bit frame and receives and checks its reply
`default_nettype none

module sd_cmd_trx import sd_init_pkg::*; (
    input  wire         i_clk,
    input  wire         i_nrst,
    input  wire         i_sclk_rise,
    input  wire         i_sclk_fall,
    input  wire         i_sd_cmd,
    output logic        o_sd_cmd,
    output logic        o_sd_cmd_dir,                       // 1 while listening
    input  wire         i_req_valid,
    input  sd_cmd_e     i_req_cmd,
    input  wire  [31:0] i_req_arg,
    input  sd_resp_e    i_req_resp,
    output logic        o_req_ready,
    output logic        o_resp_valid,
    output logic [5:0]  o_resp_cmd,
    output logic [31:0] o_resp_reg,
    output sd_cmd_err_e o_resp_err,
    output logic        o_crc7_clear,
    output logic        o_crc7_next,
    output logic        o_crc7_dat,
    input  wire  [6:0]  i_crc7
);

    typedef enum logic [2:0] {T_IDLE, T_SEND, T_WAIT_START, T_RECV, T_DONE} trx_state_e;

    trx_state_e  state;
    logic [7:0]  bitcnt;                                    // Frame bit position
    logic [6:0]  wdog;
    logic        timed_out;
    logic [39:0] tx_sh;
    logic [38:0] rx_sh;                                     // Reply bits 1..39
    logic [6:0]  crc_rx;
    sd_cmd_e     cmd_q;
    sd_resp_e    resp_q;

    assign o_req_ready  = (state == T_IDLE);
    assign o_resp_valid = (state == T_DONE);
    assign o_resp_cmd   = rx_sh[37:32];
    assign o_resp_reg   = rx_sh[31:0];

    // A zero start bit leaves a cleared CRC at zero, so clearing through
    // the wait state lets reception feed bits 1..39 only
    assign o_crc7_clear = (state == T_IDLE) || (state == T_WAIT_START);
    assign o_crc7_next  = (bitcnt < 8'd40) &&
                          (((state == T_SEND) && i_sclk_fall) ||
                           ((state == T_RECV) && i_sclk_rise));
    assign o_crc7_dat   = (state == T_SEND) ? tx_sh[39] : i_sd_cmd;

    always_comb begin
        o_resp_err = ERR_NONE;
        if (timed_out) begin
            o_resp_err = ERR_NO_RESPONSE;
        end else if (resp_echo(resp_q)) begin
            if (rx_sh[37:32] != cmd_q) begin
                o_resp_err = ERR_INDEX;
            end else if (crc_rx != i_crc7) begin
                o_resp_err = ERR_CRC;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state        <= T_IDLE;
            bitcnt       <= '0;
            wdog         <= '0;
            timed_out    <= 1'b0;
            o_sd_cmd     <= 1'b1;
            o_sd_cmd_dir <= 1'b0;
        end else begin
            case (state)
            T_IDLE: if (i_req_valid) begin
                state     <= T_SEND;
                bitcnt    <= '0;
                timed_out <= 1'b0;
            end
            T_SEND: if (i_sclk_fall) begin
                bitcnt <= bitcnt + 8'd1;
                if (bitcnt == 8'd40) begin
                    o_sd_cmd <= i_crc7[6];
                end else if (bitcnt < 8'd48) begin
                    o_sd_cmd <= tx_sh[39];
                end else begin                              // Turn the line around
                    o_sd_cmd     <= 1'b1;
                    o_sd_cmd_dir <= 1'b1;
                    wdog         <= '0;
                    state        <= (resp_q == RESP_NONE) ? T_DONE : T_WAIT_START;
                end
            end
            T_WAIT_START: if (i_sclk_rise) begin
                if (!i_sd_cmd) begin
                    state  <= T_RECV;
                    bitcnt <= 8'd1;
                end else if (wdog == 7'(RESP_TIMEOUT - 1)) begin
                    timed_out <= 1'b1;
                    state     <= T_DONE;
                end else begin
                    wdog <= wdog + 7'd1;
                end
            end
            T_RECV: if (i_sclk_rise) begin
                bitcnt <= bitcnt + 8'd1;
                if (bitcnt == resp_len(resp_q) - 8'd1) state <= T_DONE;
            end
            default: begin                                  // T_DONE
                o_sd_cmd_dir <= 1'b0;
                state        <= T_IDLE;
            end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if ((state == T_IDLE) && i_req_valid) begin
            tx_sh  <= {1'b0, 1'b1, i_req_cmd, i_req_arg};
            cmd_q  <= i_req_cmd;
            resp_q <= i_req_resp;
        end else if ((state == T_SEND) && i_sclk_fall) begin
            if (bitcnt == 8'd40) tx_sh <= {i_crc7[5:0], 1'b1, 33'd0};   // CRC tail, end bit
            else tx_sh <= {tx_sh[38:0], 1'b0};
        end
        if ((state == T_RECV) && i_sclk_rise) begin
            if (bitcnt < 8'd40) rx_sh <= {rx_sh[37:0], i_sd_cmd};
            else if (bitcnt < 8'd47) crc_rx <= {crc_rx[5:0], i_sd_cmd};
        end
    end

    a_resp_one_cycle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_resp_valid |=> !o_resp_valid);
    a_listen_in_recv: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (state == T_RECV) |-> o_sd_cmd_dir);

endmodule

`default_nettype wire

// ==== rtl/sd_init_ctrl.sv ====
// Card identification FSM that issues init commands and records card facts
`default_nettype none

module sd_init_ctrl import sd_init_pkg::*; (
    input  wire         i_clk,
    input  wire         i_nrst,
    input  wire         i_sclk_rise,
    output logic        o_req_valid,
    output sd_cmd_e     o_req_cmd,
    output logic [31:0] o_req_arg,
    output sd_resp_e    o_req_resp,
    input  wire         i_req_ready,
    input  wire         i_resp_valid,
    input  wire  [5:0]  i_resp_cmd,
    input  wire  [31:0] i_resp_reg,
    input  sd_cmd_err_e i_resp_err,
    output sd_state_e   o_sd_state,
    output sd_type_e    o_sd_type,
    output logic        o_hcs,
    output logic [15:0] o_rca
);

    typedef enum logic [3:0] {
        SUB_CMD0, SUB_CMD8, SUB_CMD55, SUB_ACMD41, SUB_CHECK_OCR,
        SUB_CMD11, SUB_CMD2, SUB_CHECK_CID, SUB_CMD3, SUB_CHECK_RCA
    } sub_e;

    sub_e        sub;
    sub_e        nxt_sub;
    logic        wait_resp;
    logic [6:0]  clkcnt;
    logic        s18;                                       // S18R request, then S18A
    logic        pwr_up;                                    // OCR bit 31 of the last R3
    logic        cmd_step;
    logic        issue;
    logic        resp_bad;
    sd_cmd_e     nxt_cmd;
    logic [31:0] nxt_arg;
    sd_resp_e    nxt_resp;

    // Request for the current substep
    always_comb begin
        cmd_step = 1'b1;
        nxt_cmd  = CMD0;
        nxt_arg  = '0;
        nxt_resp = R1;
        nxt_sub  = sub;
        case (sub)
        SUB_CMD0: begin
            nxt_resp = RESP_NONE;
            nxt_sub  = SUB_CMD8;
        end
        SUB_CMD8: begin
            nxt_cmd  = CMD8;
            nxt_resp = R7;
            nxt_arg  = {20'd0, CMD8_VHS, CMD8_PATTERN};
            nxt_sub  = SUB_CMD55;
        end
        SUB_CMD55: begin
            nxt_cmd = CMD55;
            nxt_arg = {o_rca, 16'h0000};
            nxt_sub = SUB_ACMD41;
        end
        SUB_ACMD41: begin
            nxt_cmd  = ACMD41;
            nxt_resp = R3;
            nxt_arg  = {1'b0, o_hcs, 5'd0, s18, OCR_WINDOW};
            nxt_sub  = SUB_CHECK_OCR;
        end
        SUB_CMD11: begin
            nxt_cmd = CMD11;
            nxt_sub = SUB_CMD2;
        end
        SUB_CMD2: begin
            nxt_cmd  = CMD2;
            nxt_resp = R2;
            nxt_sub  = SUB_CHECK_CID;
        end
        SUB_CMD3: begin
            nxt_cmd  = CMD3;
            nxt_resp = R6;
            nxt_sub  = SUB_CHECK_RCA;
        end
        default: cmd_step = 1'b0;
        endcase
    end

    assign issue = cmd_step && (o_sd_state inside {ST_IDLE, ST_READY, ST_IDENT});
    // R2 and R3 skip the engine's index check and must carry 63
    assign resp_bad = (i_resp_err != ERR_NONE) ||
                      ((o_req_resp inside {R2, R3}) && (i_resp_cmd != 6'h3f));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_sd_state  <= ST_PRE_INIT;
            o_sd_type   <= TYPE_UNKNOWN;
            o_hcs       <= 1'b0;
            o_rca       <= '0;
            o_req_valid <= 1'b0;
            o_req_cmd   <= CMD0;
            o_req_arg   <= '0;
            o_req_resp  <= RESP_NONE;
            sub         <= SUB_CMD0;
            wait_resp   <= 1'b0;
            clkcnt      <= '0;
            s18         <= 1'b1;
            pwr_up      <= 1'b0;
        end else if (wait_resp) begin
            if (i_resp_valid) begin
                wait_resp <= 1'b0;
                if ((o_req_cmd == CMD8) && (i_resp_err == ERR_NO_RESPONSE)) begin
                    o_sd_type <= TYPE_V1X;                  // Version 1.x, standard capacity
                    o_hcs     <= 1'b0;
                end else if (resp_bad) begin
                    o_sd_state <= ST_INA;
                    o_sd_type  <= TYPE_UNUSABLE;
                end else if (o_req_resp == R3) begin
                    pwr_up <= i_resp_reg[31];
                    if (i_resp_reg[31]) begin
                        o_hcs <= i_resp_reg[30];            // CCS
                        s18   <= i_resp_reg[24];            // S18A
                    end
                end else if (o_req_resp == R6) begin
                    o_rca <= i_resp_reg[31:16];
                end
            end
        end else if (o_req_valid) begin
            if (i_req_ready) begin
                o_req_valid <= 1'b0;
                wait_resp   <= 1'b1;
            end
        end else if (issue) begin
            o_req_valid <= 1'b1;
            o_req_cmd   <= nxt_cmd;
            o_req_arg   <= nxt_arg;
            o_req_resp  <= nxt_resp;
            sub         <= nxt_sub;
            if (sub == SUB_CMD0) begin                      // Fresh start of identification
                o_sd_type <= TYPE_UNKNOWN;
                o_hcs     <= 1'b1;
                o_rca     <= '0;
                s18       <= 1'b1;
                pwr_up    <= 1'b0;
            end
        end else begin
            case (o_sd_state)
            ST_PRE_INIT: begin
                if (i_sclk_rise) clkcnt <= clkcnt + 7'd1;
                if (clkcnt >= 7'(PRE_INIT_CLKS)) o_sd_state <= ST_IDLE;
            end
            ST_IDLE: if (sub == SUB_CHECK_OCR) begin
                if (!pwr_up) begin
                    sub <= SUB_CMD55;                       // Card still busy
                end else begin
                    if (o_hcs) o_sd_type <= TYPE_V2X_HC;
                    else if (o_sd_type != TYPE_V1X) o_sd_type <= TYPE_V2X_SC;
                    sub        <= s18 ? SUB_CMD11 : SUB_CMD2;
                    o_sd_state <= ST_READY;
                end
            end
            ST_READY: if (sub == SUB_CHECK_CID) begin
                sub        <= SUB_CMD3;
                o_sd_state <= ST_IDENT;
            end
            ST_IDENT: if (sub == SUB_CHECK_RCA) o_sd_state <= ST_STBY;
            default: ;
            endcase
        end
    end

    a_req_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_req_valid && !i_req_ready) |=>
        (o_req_valid && $stable(o_req_cmd) && $stable(o_req_arg) && $stable(o_req_resp)));

endmodule

`default_nettype wire

// ==== rtl/sd_host_top.sv ====
// SD host init top with clock divider, init FSM, command engine and CRC7
`default_nettype none

module sd_host_top import sd_init_pkg::*; (
    input  wire         i_clk,
    input  wire         i_nrst,
    input  wire         i_sd_cmd,
    output logic        o_sd_cmd,
    output logic        o_sd_cmd_dir,
    output logic        o_sd_clk,
    output sd_state_e   o_sd_state,
    output sd_type_e    o_sd_type,
    output logic        o_hcs,
    output logic [15:0] o_rca
);

    logic        sclk_rise;
    logic        sclk_fall;
    logic        req_valid;
    sd_cmd_e     req_cmd;
    logic [31:0] req_arg;
    sd_resp_e    req_resp;
    logic        req_ready;
    logic        resp_valid;
    logic [5:0]  resp_cmd;
    logic [31:0] resp_reg;
    sd_cmd_err_e resp_err;
    logic        crc7_clear;
    logic        crc7_next;
    logic        crc7_dat;
    logic [6:0]  crc7;

    sd_clk_gen u_clk_gen (
        .i_clk(i_clk), .i_nrst(i_nrst), .o_sd_clk(o_sd_clk),
        .o_sclk_rise(sclk_rise), .o_sclk_fall(sclk_fall)
    );

    sd_init_ctrl u_init_ctrl (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_sclk_rise(sclk_rise),
        .o_req_valid(req_valid), .o_req_cmd(req_cmd), .o_req_arg(req_arg),
        .o_req_resp(req_resp), .i_req_ready(req_ready),
        .i_resp_valid(resp_valid), .i_resp_cmd(resp_cmd), .i_resp_reg(resp_reg),
        .i_resp_err(resp_err), .o_sd_state(o_sd_state), .o_sd_type(o_sd_type),
        .o_hcs(o_hcs), .o_rca(o_rca)
    );

    sd_cmd_trx u_cmd_trx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_sclk_rise(sclk_rise), .i_sclk_fall(sclk_fall),
        .i_sd_cmd(i_sd_cmd), .o_sd_cmd(o_sd_cmd), .o_sd_cmd_dir(o_sd_cmd_dir),
        .i_req_valid(req_valid), .i_req_cmd(req_cmd), .i_req_arg(req_arg),
        .i_req_resp(req_resp), .o_req_ready(req_ready),
        .o_resp_valid(resp_valid), .o_resp_cmd(resp_cmd), .o_resp_reg(resp_reg),
        .o_resp_err(resp_err), .o_crc7_clear(crc7_clear), .o_crc7_next(crc7_next),
        .o_crc7_dat(crc7_dat), .i_crc7(crc7)
    );

    sd_crc7 u_crc7 (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_clear(crc7_clear),
        .i_next(crc7_next), .i_dat(crc7_dat), .o_crc7(crc7)
    );

endmodule

`default_nettype wire

// ==== test/sd_card_model.sv ====
// Behavioral SD card that decodes host command frames and answers them
`default_nettype none

module sd_card_model import sd_init_pkg::*; (
    input  wire        i_nrst,
    input  wire        i_sd_clk,
    input  wire        i_cmd,                               // Host command line
    input  wire        i_cmd_dir,
    output logic       o_cmd,                               // Card reply line, idles high
    input  wire        i_answer_cmd8,
    input  wire  [3:0] i_busy_cnt,
    input  wire        i_ccs,
    input  wire        i_s18a,
    input  wire [15:0] i_rca,
    input  wire        i_crc_err,
    input  wire  [5:0] i_crc_cmd                            // Reply that gets a corrupted CRC
);

    logic [5:0]  rx_cmd[$];
    logic [31:0] rx_arg[$];
    logic        rx_frame_ok[$];                            // CRC7, transmission and end bit good
    int          pre_clks;
    logic        seen_frame;
    int          busy_left;
    logic [47:0] frame;

    function automatic logic [6:0] crc7_calc(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) crc = crc ^ 7'h09;                      // x^3 + 1 taps
        end
        return crc;
    endfunction

    function automatic logic [47:0] short_reply(input logic [5:0] idx, input logic [31:0] body,
                                                input logic flip);
        logic [39:0] head;
        head = {2'b00, idx, body};
        return {head, crc7_calc(head) ^ {6'd0, flip}, 1'b1};
    endfunction

    // Replies start two card clocks after the command end bit
    task automatic send_reply(input logic [135:0] bits, input int len);
        repeat (2) @(negedge i_sd_clk);
        for (int i = len - 1; i >= 0; i--) begin
            o_cmd = bits[i];
            @(negedge i_sd_clk);
        end
        o_cmd = 1'b1;
    endtask

    task automatic handle_frame(input logic [47:0] f);
        logic [5:0]  idx;
        logic [31:0] arg;
        logic [31:0] ocr;
        logic        flip;
        idx  = f[45:40];
        arg  = f[39:8];
        flip = i_crc_err && (idx == i_crc_cmd);
        rx_cmd.push_back(idx);
        rx_arg.push_back(arg);
        rx_frame_ok.push_back((f[7:1] == crc7_calc(f[47:8])) && f[46] && f[0]);
        case (idx)
        6'd0:  busy_left = i_busy_cnt;
        6'd8:  if (i_answer_cmd8) send_reply(short_reply(6'd8, arg, flip), 48);
        6'd55: send_reply(short_reply(6'd55, 32'h0000_0120, flip), 48);
        6'd41: begin
            if (busy_left > 0) begin
                busy_left--;
                ocr = {8'h00, OCR_WINDOW};                  // Still powering up
            end else begin
                ocr = {1'b1, i_ccs & arg[30], 5'd0, i_s18a & arg[24], OCR_WINDOW};
            end
            send_reply({2'b00, 6'h3f, ocr, 8'hff}, 48);
        end
        6'd11: send_reply(short_reply(6'd11, 32'h0000_0920, flip), 48);
        6'd2:  send_reply({2'b00, 6'h3f, {4{32'h5a3c_e1f1}}}, 136);
        6'd3:  send_reply(short_reply(6'd3, {i_rca, 16'h0500}, flip), 48);
        default: ;
        endcase
    endtask

    always @(negedge i_nrst) begin
        pre_clks   = 0;
        seen_frame = 1'b0;
        o_cmd      = 1'b1;
    end

    initial begin
        o_cmd      = 1'b1;
        pre_clks   = 0;
        seen_frame = 1'b0;
        busy_left  = 0;
        forever begin
            @(posedge i_sd_clk);
            if (i_nrst && !i_cmd_dir && !i_cmd) begin   // Start bit
                frame[47] = 1'b0;
                for (int i = 46; i >= 0; i--) begin
                    @(posedge i_sd_clk);
                    frame[i] = i_cmd;
                end
                seen_frame = 1'b1;
                handle_frame(frame);
            end else if (i_nrst && !seen_frame) begin
                pre_clks++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_sd_host.sv ====
// Testbench for the SD host init sequencer against a behavioral card
`default_nettype none

module tb_sd_host import sd_init_pkg::*; ();

    logic        clk;
    logic        nrst;
    logic        card_cmd;
    logic        host_cmd;
    logic        host_dir;
    logic        sd_clk;
    sd_state_e   sd_state;
    sd_type_e    sd_type;
    logic        hcs;
    logic [15:0] rca;

    logic        cfg_ans8;
    logic [3:0]  cfg_busy;
    logic        cfg_ccs;
    logic        cfg_s18a;
    logic [15:0] cfg_rca;
    logic        cfg_crc_err;
    logic [5:0]  cfg_crc_cmd;

    logic [5:0]  exp_cmd[0:31];
    logic [31:0] exp_arg[0:31];
    int          exp_n;
    logic        exp_stop;                                  // Sequence ends on a bad reply
    sd_state_e   exp_state;
    sd_type_e    exp_type;
    logic        exp_hcs;
    logic [15:0] exp_rca;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          scenarios;
    event        scen_done;
    logic        cmp_pending;                               // Comparison of a scenario underway

    sd_host_top u_sd_host_top (
        .i_clk(clk), .i_nrst(nrst), .i_sd_cmd(card_cmd), .o_sd_cmd(host_cmd),
        .o_sd_cmd_dir(host_dir), .o_sd_clk(sd_clk), .o_sd_state(sd_state),
        .o_sd_type(sd_type), .o_hcs(hcs), .o_rca(rca)
    );

    sd_card_model u_card (
        .i_nrst(nrst), .i_sd_clk(sd_clk), .i_cmd(host_cmd), .i_cmd_dir(host_dir),
        .o_cmd(card_cmd), .i_answer_cmd8(cfg_ans8), .i_busy_cnt(cfg_busy), .i_ccs(cfg_ccs),
        .i_s18a(cfg_s18a), .i_rca(cfg_rca), .i_crc_err(cfg_crc_err), .i_crc_cmd(cfg_crc_cmd)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic void push_expected(input logic [5:0] idx, input logic [31:0] arg);
        if (!exp_stop) begin
            exp_cmd[exp_n] = idx;
            exp_arg[exp_n] = arg;
            exp_n++;
            // Only R1, R6 and R7 replies carry a checked CRC
            if (cfg_crc_err && (idx == cfg_crc_cmd) && (idx inside {6'd3, 6'd8, 6'd11, 6'd55}))
                exp_stop = 1'b1;
        end
    endfunction

    // Expected command list and card facts from the SD init rules
    function automatic void compute_expected();
        exp_n    = 0;
        exp_stop = 1'b0;
        push_expected(6'd0, 32'h0);
        push_expected(6'd8, {20'd0, CMD8_VHS, CMD8_PATTERN});
        for (int i = 0; i <= cfg_busy; i++) begin
            push_expected(6'd55, 32'h0);
            push_expected(6'd41, {1'b0, cfg_ans8, 5'd0, 1'b1, OCR_WINDOW});
        end
        if (cfg_s18a) push_expected(6'd11, 32'h0);
        push_expected(6'd2, 32'h0);
        push_expected(6'd3, 32'h0);
        exp_hcs   = cfg_ans8 & cfg_ccs;
        exp_rca   = cfg_rca;
        exp_state = exp_stop ? ST_INA : ST_STBY;
        if (exp_stop) exp_type = TYPE_UNUSABLE;
        else if (exp_hcs) exp_type = TYPE_V2X_HC;
        else exp_type = cfg_ans8 ? TYPE_V2X_SC : TYPE_V1X;
    endfunction

    task automatic run_scenario(input logic ans8, input logic [3:0] busy, input logic ccs,
                                input logic s18a, input logic [15:0] card_rca,
                                input logic crc_err, input logic [5:0] crc_cmd);
        @(negedge clk);
        nrst        = 1'b0;
        cfg_ans8    = ans8;
        cfg_busy    = busy;
        cfg_ccs     = ccs;
        cfg_s18a    = s18a;
        cfg_rca     = card_rca;
        cfg_crc_err = crc_err;
        cfg_crc_cmd = crc_cmd;
        repeat (16) @(negedge clk);
        check("o_sd_cmd in reset", host_cmd, 1'b1);
        check("o_sd_cmd_dir in reset", host_dir, 1'b0);
        check("o_sd_clk in reset", sd_clk, 1'b0);
        check("o_sd_state in reset", 64'(sd_state), 64'(ST_PRE_INIT));
        check("o_sd_type in reset", 64'(sd_type), 64'(TYPE_UNKNOWN));
        check("o_hcs in reset", hcs, 1'b0);
        check("o_rca in reset", rca, 16'h0000);
        u_card.rx_cmd.delete();
        u_card.rx_arg.delete();
        u_card.rx_frame_ok.delete();
        compute_expected();
        nrst = 1'b1;
        @(negedge clk);
        while (!(sd_state inside {ST_STBY, ST_INA})) @(negedge clk);
        scenarios++;
        cmp_pending = 1'b1;
        -> scen_done;
        wait (!cmp_pending);
    endtask

    // Compares recorded frames and final outputs after each scenario
    initial begin
        forever begin
            @(scen_done);
            check("command count", u_card.rx_cmd.size(), exp_n);
            for (int i = 0; i < exp_n && i < u_card.rx_cmd.size(); i++) begin
                check($sformatf("command %0d index", i), u_card.rx_cmd[i], exp_cmd[i]);
                check($sformatf("command %0d argument", i), u_card.rx_arg[i], exp_arg[i]);
                check($sformatf("command %0d crc7/end bit", i), u_card.rx_frame_ok[i], 1'b1);
            end
            check("pre-init clocks >= PRE_INIT_CLKS", u_card.pre_clks >= PRE_INIT_CLKS, 1'b1);
            check("o_sd_state", 64'(sd_state), 64'(exp_state));
            check("o_sd_type", 64'(sd_type), 64'(exp_type));
            if (!exp_stop) begin
                check("o_hcs", hcs, exp_hcs);
                check("o_rca", rca, exp_rca);
            end
            cmp_pending = 1'b0;
        end
    end

    initial begin
        logic [3:0]  busy;
        logic        ccs;
        logic        s18a;
        logic [15:0] r_rca;
        nrst = 1'b0;
        {cfg_ans8, cfg_busy, cfg_ccs, cfg_s18a, cfg_rca, cfg_crc_err, cfg_crc_cmd} = '0;
        lfsr        = 32'h52d4572e;
        errors      = 0;
        checks      = 0;
        scenarios   = 0;
        cmp_pending = 1'b0;
        run_scenario(1'b1, 4'd2, 1'b1, 1'b0, 16'hb368, 1'b0, 6'd0);     // V2 high capacity
        run_scenario(1'b0, 4'd1, 1'b1, 1'b0, 16'h1234, 1'b0, 6'd0);     // No CMD8 reply
        run_scenario(1'b1, 4'd0, 1'b0, 1'b1, 16'h4321, 1'b0, 6'd0);     // 1.8 V accepted
        run_scenario(1'b1, 4'd1, 1'b1, 1'b0, 16'h0007, 1'b1, 6'd3);     // Bad CMD3 CRC
        for (int n = 0; n < 10; n++) begin
            busy  = 4'(rand_bits(2));
            ccs   = rand_bits(1);
            s18a  = rand_bits(1);
            r_rca = 16'(rand_bits(16));
            run_scenario(1'b1, busy, ccs, s18a, r_rca, 1'b0, 6'd0);
        end
        $display("scenarios %0d, checks %0d, errors %0d", scenarios, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Scenarios x worst frame count x frame time in card clocks x card clock period
    initial begin
        longint limit;
        limit = 64'd14 * 64'd16 * 64'd256 * (64'd16 * SD_CLK_DIV);
        #(limit);
        $display("timeout: card initialization did not finish within %0d time units", limit);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/sd_init_pkg.sv
rtl/sd_clk_gen.sv
rtl/sd_crc7.sv
rtl/sd_cmd_trx.sv
rtl/sd_init_ctrl.sv
rtl/sd_host_top.sv
test/sd_card_model.sv
test/tb_sd_host.sv

// ==== Bender.yml ====
package:
  name: sd_host_init

sources:
  - rtl/sd_init_pkg.sv
  - rtl/sd_clk_gen.sv
  - rtl/sd_crc7.sv
  - rtl/sd_cmd_trx.sv
  - rtl/sd_init_ctrl.sv
  - rtl/sd_host_top.sv
  - target: test
    files:
      - test/sd_card_model.sv
      - test/tb_sd_host.sv
